/* Makefile */
VERILATOR ?= verilator
TOP       ?= process_audio_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wall

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+verilog
verilog/audio_pkg.sv
verilog/offset_estimator.sv
verilog/anti_alias_fir.sv
verilog/process_audio.sv
test/process_audio_assertions.sv
test/process_audio_tb.sv

/* test/audio_stimulus.mem */
// columns: trigger, sample, offset_valid, dc_offset, kept, processed (hex)
// dc_offset is only compared where offset_valid is 1
0 03EC 0 0000 1 0010
0 03E4 0 0000 0 0000
0 03EB 0 0000 1 010A
0 03E5 0 0000 0 0000
0 03EC 0 0000 1 02FE
0 03E4 0 0000 0 0000
0 03EA 0 0000 1 03F8
0 03E6 0 0000 0 0000
0 03EC 0 0000 1 0407
0 03E8 0 0000 0 0000
0 03E9 0 0000 1 0407
0 03E7 0 0000 0 0000
0 03EC 0 0000 1 0408
0 03E8 0 0000 0 0000
0 03E8 0 0000 1 0408
0 03E8 1 03E8 0 0000
0 03E8 1 03E8 1 03F9
0 03E8 1 03E8 0 0000
0 03E8 1 03E8 1 02FE
0 03E8 1 03E8 0 0000
1 FF38 1 03E8 1 00F7
0 FF38 1 03E8 0 0000
0 FF38 1 03E8 1 FED1
0 FF38 1 03E8 0 0000
0 FF38 1 03E8 1 FC69
0 FF38 1 03E8 0 0000
0 FF38 1 03E8 1 FB3D
0 FF38 1 03E8 0 0000
0 FF38 1 03E8 1 FB2B
0 FF38 1 03E8 0 0000
0 FF38 1 03E8 1 FB2B
0 FF38 1 03E8 0 0000
0 FF38 1 03E8 1 FB2B
0 FF38 1 03E8 0 0000
0 FF38 1 03E8 1 FB2B
0 FF38 1 FF38 0 0000
0 7F37 1 FF38 1 FD3D
0 7F37 1 FF38 0 0000
0 7F37 1 FF38 1 1E69
0 7F37 1 FF38 0 0000
0 7F37 1 FF38 1 60C0
0 7F37 1 FF38 0 0000
0 7F37 1 FF38 1 7FFF
0 8000 1 FF38 0 0000
0 8000 1 FF38 1 700F
0 8000 1 FF38 0 0000
0 8000 1 FF38 1 0067
0 8000 1 FF38 0 0000
0 8000 1 FF38 1 90BF
0 8000 1 FF38 0 0000
0 8000 1 FF38 1 8000

/* test/process_audio_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module process_audio_assertions (
    input wire logic audio_clk,
    input wire logic rst_in,
    input wire logic mic_data_valid,
    input wire logic offset_valid,
    input wire logic processed_valid
);

    int fail_count = 0;   // failed assertions so far

    // registered outputs clear one edge into reset
    assert property (@(posedge audio_clk) rst_in |=> (!processed_valid && !offset_valid))
        else begin
            $error("processed_valid or offset_valid high during reset");
            fail_count++;
        end

    // decimated stream never produces back-to-back strobes
    assert property (@(posedge audio_clk) disable iff (rst_in)
        processed_valid |=> !processed_valid)
        else begin
            $error("processed_valid high in two consecutive cycles");
            fail_count++;
        end

    // input register, FIR register, decimator register
    assert property (@(posedge audio_clk) disable iff (rst_in)
        processed_valid |-> $past(mic_data_valid, 3))
        else begin
            $error("processed_valid not 3 cycles after mic_data_valid");
            fail_count++;
        end

endmodule

bind process_audio process_audio_assertions u_assertions (
    .audio_clk      (audio_clk),
    .rst_in         (rst_in),
    .mic_data_valid (mic_data_valid),
    .offset_valid   (offset_valid),
    .processed_valid(processed_valid)
);

`default_nettype wire

/* test/process_audio_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module process_audio_tb;
    import audio_pkg::*;

    localparam int NUM_LINES = 51;
    localparam int FIELDS = 6;          // trig, sample, ov, dc, kept, processed
    localparam int SLOT = 8;            // cycles per input sample
    localparam int CYCLE_LIMIT = NUM_LINES * SLOT + 200;

    logic audio_clk;
    logic rst_in;
    logic mic_data_valid;
    logic audio_trigger;
    sample_t raw_audio_single_cycle;
    sample_t raw_audio_in;
    sample_t processed_audio;
    sample_t dc_offset;
    logic offset_valid;
    logic processed_valid;

    logic [15:0] stim [NUM_LINES*FIELDS];
    logic [15:0] expected_q [$];        // kept outputs still to come
    int value_errors = 0;
    int other_errors = 0;
    int cycles = 0;

    process_audio u_process_audio (
        .audio_clk             (audio_clk),
        .rst_in                (rst_in),
        .mic_data_valid        (mic_data_valid),
        .audio_trigger         (audio_trigger),
        .raw_audio_single_cycle(raw_audio_single_cycle),
        .raw_audio_in          (raw_audio_in),
        .processed_audio       (processed_audio),
        .dc_offset             (dc_offset),
        .offset_valid          (offset_valid),
        .processed_valid       (processed_valid)
    );

    initial audio_clk = 1'b0;
    always #2 audio_clk = ~audio_clk;

    // ########################################################################
    // output monitor and run limit
    // ########################################################################

    always @(posedge audio_clk) begin
        logic [15:0] want;
        if (!rst_in && processed_valid) begin
            if (expected_q.size() == 0) begin
                $display("processed_valid pulsed at %0t with no kept sample pending", $time);
                other_errors++;
            end else begin
                want = expected_q.pop_front();
                if (processed_audio !== want) begin
                    $display("[FAIL] %0t: processed_audio %0d, expected %0d",
                             $time, processed_audio, $signed(want));
                    value_errors++;
                end
            end
        end
    end

    always @(posedge audio_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // ########################################################################
    // stimulus
    // ########################################################################

    task automatic send_line(input int n);
        logic [15:0] trig;
        logic [15:0] sample;
        logic [15:0] ov;
        logic [15:0] dc;
        logic [15:0] kept;
        logic [15:0] proc_val;
        trig = stim[n*FIELDS];
        sample = stim[n*FIELDS+1];
        ov = stim[n*FIELDS+2];
        dc = stim[n*FIELDS+3];
        kept = stim[n*FIELDS+4];
        proc_val = stim[n*FIELDS+5];
        @(posedge audio_clk);
        audio_trigger <= trig[0];
        @(posedge audio_clk);
        audio_trigger <= 1'b0;
        mic_data_valid <= 1'b1;
        raw_audio_single_cycle <= sample;
        if (kept[0]) begin
            expected_q.push_back(proc_val);
        end
        @(posedge audio_clk);
        mic_data_valid <= 1'b0;
        raw_audio_single_cycle <= ~sample;   // bus data is only good with the strobe
        @(posedge audio_clk);
        if (raw_audio_in !== sample) begin
            $display("[FAIL] %0t: raw_audio_in %0d, expected %0d",
                     $time, raw_audio_in, $signed(sample));
            value_errors++;
        end
        repeat (3) @(posedge audio_clk);
        @(posedge audio_clk);   // offset from this sample's window has landed by now
        if (raw_audio_in !== sample) begin
            $display("[FAIL] %0t: raw_audio_in %0d not held after line %0d, expected %0d",
                     $time, raw_audio_in, n, $signed(sample));
            value_errors++;
        end
        if (offset_valid !== ov[0]) begin
            $display("[FAIL] %0t: offset_valid %0b after line %0d, expected %0b",
                     $time, offset_valid, n, ov[0]);
            value_errors++;
        end
        if (ov[0] && dc_offset !== dc) begin
            $display("[FAIL] %0t: dc_offset %0d after line %0d, expected %0d",
                     $time, dc_offset, n, $signed(dc));
            value_errors++;
        end
    endtask

    initial begin
        int fails_in_checker;
        rst_in = 1'b1;
        mic_data_valid = 1'b0;
        audio_trigger = 1'b0;
        raw_audio_single_cycle = '0;
        $readmemh("test/audio_stimulus.mem", stim);
        repeat (4) @(posedge audio_clk);
        rst_in <= 1'b0;
        for (int n = 0; n < NUM_LINES; n++) begin
            send_line(n);
        end
        repeat (10) @(posedge audio_clk);
        if (expected_q.size() != 0) begin
            $display("%0d kept outputs never appeared", expected_q.size());
            other_errors++;
        end
        fails_in_checker = u_process_audio.u_assertions.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, fails_in_checker);
        if (value_errors == 0 && other_errors == 0 && fails_in_checker == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/anti_alias_fir.sv */
`timescale 1ns/10ps
`default_nettype none

`include "audio_settings.svh"

module anti_alias_fir (
    input  wire logic          audio_clk,
    input  wire logic          rst_in,
    input  wire logic          in_valid,
    input  wire audio_pkg::sample_t in_sample,
    output logic               out_valid,
    output audio_pkg::sample_t out_sample
);
    import audio_pkg::*;

    localparam int ACC_W = `AUDIO_WIDTH + `COEF_WIDTH + $clog2(`FIR_TAPS);
    localparam int SHIFTED_W = ACC_W - `COEF_FRAC;
    localparam logic signed [SHIFTED_W-1:0] SAT_MAX = (1 <<< (`AUDIO_WIDTH - 1)) - 1;
    localparam logic signed [SHIFTED_W-1:0] SAT_MIN = -(1 <<< (`AUDIO_WIDTH - 1));

    typedef logic signed [ACC_W-1:0] fir_acc_t;

    sample_t delay_line [`FIR_TAPS-1];   // older samples, newest at index 0
    sample_t window [`FIR_TAPS];
    fir_acc_t dot;
    fir_acc_t rounded;
    logic signed [SHIFTED_W-1:0] shifted;
    sample_t saturated;

    // #####################################################################
    // delay line
    // #####################################################################

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            for (int k = 0; k < `FIR_TAPS - 1; k++) begin
                delay_line[k] <= '0;
            end
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                delay_line[0] <= in_sample;
                for (int k = 1; k < `FIR_TAPS - 1; k++) begin
                    delay_line[k] <= delay_line[k-1];
                end
            end
        end
    end

    // #####################################################################
    // dot product, rounding and saturation
    // #####################################################################

    // incoming sample takes part in this cycle's output
    always_comb begin
        window[0] = in_sample;
        for (int k = 1; k < `FIR_TAPS; k++) begin
            window[k] = delay_line[k-1];
        end
    end

    always_comb begin
        dot = '0;
        for (int k = 0; k < `FIR_TAPS; k++) begin
            dot = dot + fir_acc_t'(window[k]) * fir_acc_t'(FIR_COEFS[k]);
        end
        rounded = dot + fir_acc_t'(1 << (`COEF_FRAC - 1));   // round half up
        shifted = rounded[ACC_W-1:`COEF_FRAC];
        if (shifted > SAT_MAX) begin
            saturated = SAT_MAX[`AUDIO_WIDTH-1:0];
        end else if (shifted < SAT_MIN) begin
            saturated = SAT_MIN[`AUDIO_WIDTH-1:0];
        end else begin
            saturated = shifted[`AUDIO_WIDTH-1:0];
        end
    end

    always_ff @(posedge audio_clk) begin
        if (in_valid) begin
            out_sample <= saturated;
        end
    end

endmodule

`default_nettype wire

/* verilog/audio_pkg.sv */
`default_nettype none

`include "audio_settings.svh"

package audio_pkg;

    // one microphone sample, two's complement
    typedef logic signed [`AUDIO_WIDTH-1:0] sample_t;

    // room for a full window of samples without overflow
    typedef logic signed [`AUDIO_WIDTH+`OFFSET_LOG2-1:0] offset_acc_t;

    typedef enum logic [1:0] {
        OFS_IDLE,
        OFS_ACCUM,
        OFS_DONE
    } offset_state_t;

    typedef logic signed [`COEF_WIDTH-1:0] coef_t;

    // symmetric low-pass, dc gain 33792/32768
    parameter coef_t FIR_COEFS [`FIR_TAPS] = '{
        16'sd512, 16'sd2048, 16'sd6144, 16'sd8192,
        16'sd8192, 16'sd6144, 16'sd2048, 16'sd512
    };

endpackage

`default_nettype wire

/* verilog/audio_settings.svh */
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// #########################################################################
// sample format
// #########################################################################

`define AUDIO_WIDTH 16

// coefficients are Q1.15
`define COEF_WIDTH 16
`define COEF_FRAC 15

// #########################################################################
// front end sizes
// #########################################################################

`define OFFSET_LOG2 4   // averaging window of 16 raw samples
`define FIR_TAPS 8
`define DECIM_LOG2 1    // 48 kHz down to 24 kHz

`endif

/* verilog/offset_estimator.sv */
`timescale 1ns/10ps
`default_nettype none

`include "audio_settings.svh"

module offset_estimator (
    input  wire logic          audio_clk,
    input  wire logic          rst_in,
    input  wire logic          start,
    input  wire logic          sample_valid,
    input  wire audio_pkg::sample_t sample,
    output logic               offset_produced,
    output audio_pkg::sample_t offset
);
    import audio_pkg::*;

    offset_state_t state;
    offset_acc_t acc;
    offset_acc_t mean;
    logic [`OFFSET_LOG2-1:0] count;   // samples taken so far in this window

    // #####################################################################
    // window control
    // #####################################################################

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= OFS_IDLE;
            count <= '0;
        end else if (start) begin
            // a new request always restarts the window
            state <= OFS_ACCUM;
            count <= '0;
        end else begin
            case (state)
                OFS_ACCUM: begin
                    if (sample_valid) begin
                        count <= count + 1'b1;
                        if (count == '1) begin
                            state <= OFS_DONE;   // last sample of the window
                        end
                    end
                end
                OFS_DONE: begin
                    state <= OFS_IDLE;
                end
                default: begin
                    state <= OFS_IDLE;
                end
            endcase
        end
    end

    // #####################################################################
    // running sum
    // #####################################################################

    always_ff @(posedge audio_clk) begin
        if (start) begin
            acc <= '0;
        end else if (state == OFS_ACCUM && sample_valid) begin
            acc <= acc + offset_acc_t'(sample);
        end
    end

    // mean is the sum over a power-of-two window, so a shift does the divide
    assign mean = acc >>> `OFFSET_LOG2;
    assign offset = mean[`AUDIO_WIDTH-1:0];
    assign offset_produced = (state == OFS_DONE);   // one cycle only

endmodule

`default_nettype wire

/* verilog/process_audio.sv */
`timescale 1ns/10ps
`default_nettype none

`include "audio_settings.svh"

module process_audio (
    input  wire logic          audio_clk,
    input  wire logic          rst_in,
    input  wire logic          mic_data_valid,
    input  wire logic          audio_trigger,
    input  wire audio_pkg::sample_t raw_audio_single_cycle,
    output audio_pkg::sample_t raw_audio_in,
    output audio_pkg::sample_t processed_audio,
    output audio_pkg::sample_t dc_offset,
    output logic               offset_valid,
    output logic               processed_valid
);
    import audio_pkg::*;

    logic raw_valid;          // raw_audio_in was loaded last edge
    logic rst_d;
    logic trig_d;
    logic start;
    logic est_offset_produced;
    sample_t est_offset;
    sample_t dc_blocked;
    logic fir_out_valid;
    sample_t fir_out_sample;
    logic [`DECIM_LOG2-1:0] decim_cnt;

    // #####################################################################
    // input register and estimator start
    // #####################################################################

    always_ff @(posedge audio_clk) begin
        if (mic_data_valid) begin
            raw_audio_in <= raw_audio_single_cycle;
        end
    end

    always_ff @(posedge audio_clk) begin
        rst_d <= rst_in;
        if (rst_in) begin
            raw_valid <= 1'b0;
            trig_d <= 1'b0;
        end else begin
            raw_valid <= mic_data_valid;
            trig_d <= audio_trigger;
        end
    end

    // first cycle out of reset, or one cycle after a trigger
    assign start = (rst_d & ~rst_in) | trig_d;

    offset_estimator u_offset_estimator (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .start          (start),
        .sample_valid   (raw_valid),
        .sample         (raw_audio_in),
        .offset_produced(est_offset_produced),
        .offset         (est_offset)
    );

    // #####################################################################
    // offset hold and dc removal
    // #####################################################################

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            offset_valid <= 1'b0;
        end else if (est_offset_produced) begin
            offset_valid <= 1'b1;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (est_offset_produced) begin
            dc_offset <= est_offset;   // old value stays until a new window ends
        end
    end

    assign dc_blocked = offset_valid ? raw_audio_in - dc_offset : raw_audio_in;

    anti_alias_fir u_anti_alias_fir (
        .audio_clk (audio_clk),
        .rst_in    (rst_in),
        .in_valid  (raw_valid),
        .in_sample (dc_blocked),
        .out_valid (fir_out_valid),
        .out_sample(fir_out_sample)
    );

    // #####################################################################
    // decimation
    // #####################################################################

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            decim_cnt <= '0;
            processed_valid <= 1'b0;
        end else begin
            processed_valid <= fir_out_valid && (decim_cnt == '0);
            if (fir_out_valid) begin
                decim_cnt <= decim_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (fir_out_valid && decim_cnt == '0) begin
            processed_audio <= fir_out_sample;   // keep 1st, 3rd, 5th ...
        end
    end

endmodule

`default_nettype wire
